//--- list.f
harness_map_pkg.sv
harness_bus_pkg.sv
bus_router.sv
boot_rom.sv
sram_bank.sv
harness_ctrl_regs.sv
debug_req_gate.sv
harness_top.sv
tb_harness.sv

//--- Bender.yml
package:
  name: harness_sim

sources:
  - harness_map_pkg.sv
  - harness_bus_pkg.sv
  - bus_router.sv
  - boot_rom.sv
  - sram_bank.sv
  - harness_ctrl_regs.sv
  - debug_req_gate.sv
  - harness_top.sv
  - target: simulation
    files:
      - tb_harness.sv

//--- tb_harness.sv
`timescale 1ns/1ps
`default_nettype none

module tb_harness;

  localparam int unsigned Timeout = 40;
  localparam harness_bus_pkg::addr_t Holes [6] = '{
    32'h0000_0ffc, 32'h0000_1100, 32'h0000_1800,
    32'h0000_2010, 32'h8000_0400, 32'hffff_fffc
  };

  logic                       clk;
  logic                       rst_n;
  logic                       req_valid;
  logic                       req_ready;
  harness_bus_pkg::bus_req_t  req;
  logic                       resp_valid;
  logic                       resp_ready;
  harness_bus_pkg::bus_resp_t resp;
  logic                       dbg_req_in;
  logic                       dbg_req_out;
  harness_map_pkg::exit_t     exit_code;

  logic [15:0]                lfsr_q;
  logic [7:0]                 sram_model [harness_map_pkg::SramWords * 4];
  logic                       in_flight;
  int unsigned                lat;
  logic                       prev_valid;
  logic                       prev_ready;
  harness_bus_pkg::bus_resp_t prev_resp;

  harness_top i_harness_top (
    .clk_i        ( clk         ),
    .rst_ni       ( rst_n       ),
    .req_valid_i  ( req_valid   ),
    .req_ready_o  ( req_ready   ),
    .req_i        ( req         ),
    .resp_valid_o ( resp_valid  ),
    .resp_ready_i ( resp_ready  ),
    .resp_o       ( resp        ),
    .debug_req_i  ( dbg_req_in  ),
    .debug_req_o  ( dbg_req_out ),
    .exit_o       ( exit_code   )
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // --------------------------------------------------
  // Failure reporting and stimulus helpers
  // --------------------------------------------------
  task automatic halt_with_failure();
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic report_mismatch(string name, logic [63:0] got, logic [63:0] exp);
    $display("[ERROR] t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
    halt_with_failure();
  endtask

  task automatic check_eq(string name, logic [63:0] got, logic [63:0] exp);
    assert (got === exp) else report_mismatch(name, got, exp);
  endtask

  task automatic fail_timeout(string what);
    $display("Timeout: %s at t=%0t", what, $time);
    halt_with_failure();
  endtask

  // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic [31:0] lfsr_bits(int unsigned n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int unsigned i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  // One request and its response, with a random response stall
  task automatic bus_access(input harness_bus_pkg::addr_t addr, input logic we,
                            input harness_bus_pkg::data_t wdata,
                            input harness_bus_pkg::strb_t be,
                            output harness_bus_pkg::bus_resp_t rsp);
    int unsigned stall;
    int unsigned n;
    stall = lfsr_bits(3);
    @(posedge clk);
    #1;
    req_valid  = 1'b1;
    req.addr   = addr;
    req.we     = we;
    req.wdata  = wdata;
    req.be     = be;
    resp_ready = (stall == 0);
    n = 0;
    @(negedge clk);
    while (!req_ready) begin
      n++;
      if (n > Timeout) fail_timeout("request never accepted");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    req_valid = 1'b0;
    n = 0;
    @(negedge clk);
    while (!resp_valid) begin
      n++;
      if (n > Timeout) fail_timeout("no response");
      @(negedge clk);
    end
    if (stall != 0) begin
      repeat (stall) @(posedge clk);
      #1;
      resp_ready = 1'b1;
      @(negedge clk);
    end
    rsp = resp;
    @(posedge clk);
    #1;
    resp_ready = 1'b0;
  endtask

  function automatic harness_bus_pkg::data_t sram_word(int unsigned idx);
    return {sram_model[4*idx+3], sram_model[4*idx+2], sram_model[4*idx+1], sram_model[4*idx]};
  endfunction

  // --------------------------------------------------
  // Handshake monitors
  // --------------------------------------------------
  assert property (@(posedge clk) disable iff (!rst_n)
                   resp_valid && !resp_ready |=> resp_valid)
    else report_mismatch("resp_valid_o", $sampled(resp_valid), 1'b1);

  // Sampled mid-cycle, handshakes complete on the next rising edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (prev_valid && !prev_ready) begin
        assert (resp === prev_resp) else report_mismatch("resp_o", resp, prev_resp);
      end
      if (in_flight) begin
        lat++;
        assert (!req_ready) else report_mismatch("req_ready_o", req_ready, 1'b0);
        if (lat == 1) assert (!resp_valid) else report_mismatch("resp_valid_o", resp_valid, 0);
        if (lat == 2) assert (resp_valid) else report_mismatch("resp_valid_o", resp_valid, 1);
      end
      if (resp_valid && resp_ready) in_flight = 1'b0;
      if (req_valid && req_ready) begin
        in_flight = 1'b1;
        lat       = 0;
      end
      prev_valid = resp_valid;
      prev_ready = resp_ready;
      prev_resp  = resp;
    end
  end

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    harness_bus_pkg::bus_resp_t rsp;
    harness_bus_pkg::data_t     data;
    harness_bus_pkg::strb_t     be;
    int unsigned                idx;
    int unsigned                n;
    lfsr_q      = 16'd95;
    in_flight   = 1'b0;
    lat         = 0;
    prev_valid  = 1'b0;
    prev_ready  = 1'b0;
    prev_resp   = '0;
    rst_n       = 1'b0;
    req_valid   = 1'b0;
    req         = '0;
    resp_ready  = 1'b0;
    dbg_req_in  = 1'b1;
    for (int i = 0; i < harness_map_pkg::SramWords * 4; i++) sram_model[i] = 8'h00;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    @(negedge clk);
    check_eq("resp_valid_o", resp_valid, 1'b0);
    check_eq("req_ready_o", req_ready, 1'b1);
    check_eq("exit_o", exit_code, '0);

    // Debug request held off for the delay window
    n = 0;
    while (!dbg_req_out) begin
      n++;
      if (n > harness_map_pkg::DebugDelayCycles + Timeout) fail_timeout("debug_req_o never rose");
      @(negedge clk);
    end
    check_eq("debug_req_o low cycles", n, harness_map_pkg::DebugDelayCycles);

    // Request keeps passing once the window has closed
    repeat (harness_map_pkg::DebugDelayCycles) begin
      @(negedge clk);
      check_eq("debug_req_o", dbg_req_out, 1'b1);
    end

    // SRAM writes into a small window so bytes get overwritten
    for (int i = 0; i < 40; i++) begin
      idx  = lfsr_bits(4);
      be   = lfsr_bits(4);
      data = lfsr_bits(32);
      bus_access(harness_map_pkg::SramBase + 4 * idx, 1'b1, data, be, rsp);
      check_eq("resp_o.err", rsp.err, 1'b0);
      for (int b = 0; b < 4; b++) begin
        if (be[b]) sram_model[4*idx+b] = data[8*b +: 8];
      end
    end
    for (int i = 0; i < 24; i++) begin
      idx = (i < 16) ? i : lfsr_bits(8);
      bus_access(harness_map_pkg::SramBase + 4 * idx, 1'b0, '0, '0, rsp);
      check_eq("resp_o.err", rsp.err, 1'b0);
      check_eq("resp_o.rdata", rsp.rdata, sram_word(idx));
    end

    // Boot ROM reads and a rejected write
    for (int i = 0; i < 8; i++) begin
      idx = lfsr_bits(6);
      bus_access(harness_map_pkg::RomBase + 4 * idx, 1'b0, '0, '0, rsp);
      check_eq("resp_o.err", rsp.err, 1'b0);
      check_eq("resp_o.rdata", rsp.rdata, {harness_map_pkg::RomTag, 16'(idx)});
    end
    bus_access(harness_map_pkg::RomBase + 8, 1'b1, lfsr_bits(32), 4'hf, rsp);
    check_eq("resp_o.err", rsp.err, 1'b1);
    check_eq("resp_o.rdata", rsp.rdata, '0);

    // Unmapped addresses, read and write
    for (int i = 0; i < 12; i++) begin
      bus_access(Holes[i/2], i[0], lfsr_bits(32), 4'hf, rsp);
      check_eq("resp_o.err", rsp.err, 1'b1);
      check_eq("resp_o.rdata", rsp.rdata, '0);
    end

    // Control registers
    data = lfsr_bits(32);
    bus_access(harness_map_pkg::CtrlBase + harness_map_pkg::ExitOffset, 1'b1, data, 4'hf, rsp);
    check_eq("resp_o.err", rsp.err, 1'b0);
    @(negedge clk);
    check_eq("exit_o", exit_code, data);
    bus_access(harness_map_pkg::CtrlBase + harness_map_pkg::ExitOffset, 1'b0, '0, '0, rsp);
    check_eq("resp_o.rdata", rsp.rdata, data);
    bus_access(harness_map_pkg::CtrlBase + harness_map_pkg::DbgEnOffset, 1'b1, '0, 4'hf, rsp);
    @(negedge clk);
    check_eq("debug_req_o", dbg_req_out, 1'b0);
    bus_access(harness_map_pkg::CtrlBase + harness_map_pkg::DbgEnOffset, 1'b0, '0, '0, rsp);
    check_eq("resp_o.rdata", rsp.rdata, 32'h0);
    bus_access(harness_map_pkg::CtrlBase + harness_map_pkg::DbgEnOffset, 1'b1, 32'h1, 4'hf, rsp);
    @(negedge clk);
    check_eq("debug_req_o", dbg_req_out, 1'b1);
    bus_access(harness_map_pkg::CtrlBase + 32'h8, 1'b0, '0, '0, rsp);
    check_eq("resp_o.err", rsp.err, 1'b0);
    check_eq("resp_o.rdata", rsp.rdata, 32'h0);

    repeat (4) @(posedge clk);
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- harness_top.sv
`timescale 1ns/1ps
`default_nettype none

module harness_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       req_valid_i,
  output logic                       req_ready_o,
  input  harness_bus_pkg::bus_req_t  req_i,
  output logic                       resp_valid_o,
  input  logic                       resp_ready_i,
  output harness_bus_pkg::bus_resp_t resp_o,
  input  logic                       debug_req_i,
  output logic                       debug_req_o,
  output harness_map_pkg::exit_t     exit_o
);

  harness_bus_pkg::bus_req_t tgt_req;
  logic                      rom_sel;
  logic                      sram_sel;
  logic                      ctrl_sel;
  harness_bus_pkg::data_t    rom_rdata;
  harness_bus_pkg::data_t    sram_rdata;
  harness_bus_pkg::data_t    ctrl_rdata;
  logic                      dbg_en;

  // --------------------------------------------------
  // Router
  // --------------------------------------------------
  bus_router i_bus_router (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .req_valid_i  ( req_valid_i  ),
    .req_ready_o  ( req_ready_o  ),
    .req_i        ( req_i        ),
    .resp_valid_o ( resp_valid_o ),
    .resp_ready_i ( resp_ready_i ),
    .resp_o       ( resp_o       ),
    .tgt_req_o    ( tgt_req      ),
    .rom_sel_o    ( rom_sel      ),
    .sram_sel_o   ( sram_sel     ),
    .ctrl_sel_o   ( ctrl_sel     ),
    .rom_rdata_i  ( rom_rdata    ),
    .sram_rdata_i ( sram_rdata   ),
    .ctrl_rdata_i ( ctrl_rdata   )
  );

  // --------------------------------------------------
  // Targets
  // --------------------------------------------------
  // Target addresses arrive relative to their region base
  boot_rom i_boot_rom (
    .clk_i   ( clk_i                                          ),
    .sel_i   ( rom_sel                                        ),
    .idx_i   ( harness_map_pkg::rom_idx_t'(tgt_req.addr >> 2) ),
    .rdata_o ( rom_rdata                                      )
  );

  sram_bank i_sram_bank (
    .clk_i   ( clk_i                                           ),
    .sel_i   ( sram_sel                                        ),
    .we_i    ( tgt_req.we                                      ),
    .idx_i   ( harness_map_pkg::sram_idx_t'(tgt_req.addr >> 2) ),
    .be_i    ( tgt_req.be                                      ),
    .wdata_i ( tgt_req.wdata                                   ),
    .rdata_o ( sram_rdata                                      )
  );

  harness_ctrl_regs i_harness_ctrl_regs (
    .clk_i    ( clk_i                                        ),
    .rst_ni   ( rst_ni                                       ),
    .sel_i    ( ctrl_sel                                     ),
    .we_i     ( tgt_req.we                                   ),
    .offset_i ( harness_map_pkg::ctrl_off_t'(tgt_req.addr)   ),
    .wdata_i  ( tgt_req.wdata                                ),
    .rdata_o  ( ctrl_rdata                                   ),
    .exit_o   ( exit_o                                       ),
    .dbg_en_o ( dbg_en                                       )
  );

  debug_req_gate i_debug_req_gate (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .dbg_en_i    ( dbg_en      ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

endmodule

`default_nettype wire

//--- debug_req_gate.sv
`timescale 1ns/1ps
`default_nettype none

module debug_req_gate (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic dbg_en_i,
  input  logic debug_req_i,
  output logic debug_req_o
);

  harness_map_pkg::dbg_cnt_t cnt_q;
  logic                      window_done;

  assign window_done = (cnt_q == '0);

  // Hold-off counter, loaded at reset and stopping at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= harness_map_pkg::dbg_cnt_t'(harness_map_pkg::DebugDelayCycles);
    end else if (!window_done) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // Request passes only after the window and while enabled
  assign debug_req_o = debug_req_i && window_done && dbg_en_i;

endmodule

`default_nettype wire

//--- harness_ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

module harness_ctrl_regs (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       sel_i,
  input  logic                       we_i,
  input  harness_map_pkg::ctrl_off_t offset_i,
  input  harness_bus_pkg::data_t     wdata_i,
  output harness_bus_pkg::data_t     rdata_o,
  output harness_map_pkg::exit_t     exit_o,
  output logic                       dbg_en_o
);

  harness_map_pkg::exit_t exit_q;
  logic                   dbg_en_q;
  harness_bus_pkg::data_t rd_val;

  // Whole-word register writes
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exit_q   <= '0;
      dbg_en_q <= 1'b1;
    end else if (sel_i && we_i) begin
      unique case (offset_i)
        harness_map_pkg::ExitOffset:  exit_q   <= wdata_i;
        harness_map_pkg::DbgEnOffset: dbg_en_q <= wdata_i[0];
        default: ;
      endcase
    end
  end

  // Read mux, unused offsets read as zero
  always_comb begin
    rd_val = '0;
    unique case (offset_i)
      harness_map_pkg::ExitOffset:  rd_val = exit_q;
      harness_map_pkg::DbgEnOffset: rd_val[0] = dbg_en_q;
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (sel_i && !we_i) begin
      rdata_o <= rd_val;
    end
  end

  assign exit_o   = exit_q;
  assign dbg_en_o = dbg_en_q;

endmodule

`default_nettype wire

//--- sram_bank.sv
`timescale 1ns/1ps
`default_nettype none

module sram_bank (
  input  logic                       clk_i,
  input  logic                       sel_i,
  input  logic                       we_i,
  input  harness_map_pkg::sram_idx_t idx_i,
  input  harness_bus_pkg::strb_t     be_i,
  input  harness_bus_pkg::data_t     wdata_i,
  output harness_bus_pkg::data_t     rdata_o
);

  harness_bus_pkg::data_t mem_q [harness_map_pkg::SramWords];

  // Start from a cleared array
  initial begin
    for (int i = 0; i < harness_map_pkg::SramWords; i++) begin
      mem_q[i] = '0;
    end
  end

  // --------------------------------------------------
  // Byte-enable write, registered read
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      if (we_i) begin
        for (int b = 0; b < harness_bus_pkg::StrbWidth; b++) begin
          if (be_i[b]) begin
            mem_q[idx_i][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[idx_i];
      end
    end
  end

endmodule

`default_nettype wire

//--- boot_rom.sv
`timescale 1ns/1ps
`default_nettype none

module boot_rom (
  input  logic                      clk_i,
  input  logic                      sel_i,
  input  harness_map_pkg::rom_idx_t idx_i,
  output harness_bus_pkg::data_t    rdata_o
);

  harness_bus_pkg::data_t rom_word;

  // Tag in the upper half, word index in the lower half
  assign rom_word = {harness_map_pkg::RomTag, 16'(idx_i)};

  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      rdata_o <= rom_word;
    end
  end

endmodule

`default_nettype wire

//--- bus_router.sv
`timescale 1ns/1ps
`default_nettype none

module bus_router (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       req_valid_i,
  output logic                       req_ready_o,
  input  harness_bus_pkg::bus_req_t  req_i,
  output logic                       resp_valid_o,
  input  logic                       resp_ready_i,
  output harness_bus_pkg::bus_resp_t resp_o,
  output harness_bus_pkg::bus_req_t  tgt_req_o,
  output logic                       rom_sel_o,
  output logic                       sram_sel_o,
  output logic                       ctrl_sel_o,
  input  harness_bus_pkg::data_t     rom_rdata_i,
  input  harness_bus_pkg::data_t     sram_rdata_i,
  input  harness_bus_pkg::data_t     ctrl_rdata_i
);

  harness_bus_pkg::router_state_e state_d, state_q;
  harness_bus_pkg::target_e       tgt_d, tgt_q;
  harness_bus_pkg::bus_req_t      req_d, req_q;
  harness_bus_pkg::addr_t         base;
  logic                           accept;

  function automatic logic in_region(harness_bus_pkg::addr_t addr,
                                     logic [31:0] rbase, logic [31:0] rlen);
    return (addr >= rbase) && (addr < rbase + rlen);
  endfunction

  // --------------------------------------------------
  // Address decode
  // --------------------------------------------------
  always_comb begin
    tgt_d = harness_bus_pkg::TGT_NONE;
    base  = '0;
    if (in_region(req_i.addr, harness_map_pkg::RomBase, harness_map_pkg::RomLength)) begin
      // ROM is read-only, a write falls through to the error path
      if (!req_i.we) begin
        tgt_d = harness_bus_pkg::TGT_ROM;
        base  = harness_map_pkg::RomBase;
      end
    end else if (in_region(req_i.addr, harness_map_pkg::SramBase,
                           harness_map_pkg::SramLength)) begin
      tgt_d = harness_bus_pkg::TGT_SRAM;
      base  = harness_map_pkg::SramBase;
    end else if (in_region(req_i.addr, harness_map_pkg::CtrlBase,
                           harness_map_pkg::CtrlLength)) begin
      tgt_d = harness_bus_pkg::TGT_CTRL;
      base  = harness_map_pkg::CtrlBase;
    end
    req_d      = req_i;
    req_d.addr = req_i.addr - base;
  end

  // --------------------------------------------------
  // Handshake FSM
  // --------------------------------------------------
  assign req_ready_o  = (state_q == harness_bus_pkg::ST_IDLE);
  assign resp_valid_o = (state_q == harness_bus_pkg::ST_RESP);
  assign accept       = req_valid_i && req_ready_o;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      harness_bus_pkg::ST_IDLE: begin
        if (accept) state_d = harness_bus_pkg::ST_ACCESS;
      end
      harness_bus_pkg::ST_ACCESS: state_d = harness_bus_pkg::ST_RESP;
      harness_bus_pkg::ST_RESP: begin
        if (resp_ready_i) state_d = harness_bus_pkg::ST_IDLE;
      end
      default: state_d = harness_bus_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= harness_bus_pkg::ST_IDLE;
      tgt_q   <= harness_bus_pkg::TGT_NONE;
    end else begin
      state_q <= state_d;
      if (accept) tgt_q <= tgt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) req_q <= req_d;
  end

  // One select pulse during ST_ACCESS
  assign tgt_req_o  = req_q;
  assign rom_sel_o  = (state_q == harness_bus_pkg::ST_ACCESS) && (tgt_q == harness_bus_pkg::TGT_ROM);
  assign sram_sel_o = (state_q == harness_bus_pkg::ST_ACCESS) && (tgt_q == harness_bus_pkg::TGT_SRAM);
  assign ctrl_sel_o = (state_q == harness_bus_pkg::ST_ACCESS) && (tgt_q == harness_bus_pkg::TGT_CTRL);

  // Response mux, target data is held until the next select
  always_comb begin
    resp_o = '0;
    unique case (tgt_q)
      harness_bus_pkg::TGT_ROM:  resp_o.rdata = rom_rdata_i;
      harness_bus_pkg::TGT_SRAM: resp_o.rdata = sram_rdata_i;
      harness_bus_pkg::TGT_CTRL: resp_o.rdata = ctrl_rdata_i;
      default:                   resp_o.err   = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

//--- harness_bus_pkg.sv
`default_nettype none

package harness_bus_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;

  // --------------------------------------------------
  // Request and response payloads
  // --------------------------------------------------
  typedef struct packed {
    addr_t addr;
    logic  we;
    data_t wdata;
    strb_t be;
  } bus_req_t;

  typedef struct packed {
    data_t rdata;
    logic  err;
  } bus_resp_t;

  // Decoded destination of a request
  typedef enum logic [1:0] {
    TGT_ROM,
    TGT_SRAM,
    TGT_CTRL,
    TGT_NONE
  } target_e;

  // Router FSM
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ACCESS,
    ST_RESP
  } router_state_e;

endpackage

`default_nettype wire

//--- harness_map_pkg.sv
`default_nettype none

package harness_map_pkg;

  // --------------------------------------------------
  // Address map
  // --------------------------------------------------
  localparam int unsigned RomWords  = 64;
  localparam int unsigned SramWords = 256;

  localparam logic [31:0] RomBase    = 32'h0000_1000;
  localparam logic [31:0] RomLength  = RomWords * 4;
  localparam logic [31:0] CtrlBase   = 32'h0000_2000;
  localparam logic [31:0] CtrlLength = 32'h0000_0010;
  localparam logic [31:0] SramBase   = 32'h8000_0000;
  localparam logic [31:0] SramLength = SramWords * 4;

  // Word indices inside the memories
  typedef logic [5:0] rom_idx_t;
  typedef logic [7:0] sram_idx_t;

  // --------------------------------------------------
  // Control registers
  // --------------------------------------------------
  typedef logic [3:0]  ctrl_off_t;
  typedef logic [31:0] exit_t;

  localparam ctrl_off_t ExitOffset  = 4'h0;
  localparam ctrl_off_t DbgEnOffset = 4'h4;

  // Upper half of every boot ROM word
  localparam logic [15:0] RomTag = 16'hB007;

  // Debug request hold-off after reset, shortened for simulation
  localparam int unsigned DebugDelayCycles = 20;
  typedef logic [$clog2(DebugDelayCycles + 1)-1:0] dbg_cnt_t;

endpackage

`default_nettype wire
